// ==== Makefile ====
# Verilator build and run for the issue stage testbench.

VERILATOR ?= verilator
TOP ?= issue_tb
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0
PASS_TEXT ?= *** TEST PASSED ***

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '$(PASS_TEXT)' $(LOG); then \
		echo "Result: pass"; \
	else \
		echo "Result: fail"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sim.f ====
src/issue_pkg.sv
src/pair_splitter.sv
src/issue_stage.sv
src/pipe_shadow.sv
src/register_file.sv
src/issue_top.sv
verification/tb_clock.sv
verification/issue_tb.sv

// ==== src/issue_pkg.sv ====
package issue_pkg;

  localparam int data_width = 32;
  localparam int reg_count = 32;
  localparam int addr_width = 5;
  localparam int read_ports = 4; // Two sources for each of the two slots.

  // Instruction class as seen by the issue logic.
  typedef enum logic [2:0] {
    op_none,
    op_alu,
    op_load,
    op_store,
    op_csr_read,
    op_csr_write
  } op_kind_t;

  typedef struct packed {
    logic valid;
    op_kind_t kind;
    logic [data_width-1:0] pc;
    logic [addr_width-1:0] rd;
    logic [addr_width-1:0] rs1;
    logic [addr_width-1:0] rs2;
    logic rd_en;
    logic rs1_en;
    logic rs2_en;
  } slot_t;

  // Slot0 is the older instruction of the pair.
  typedef struct packed {
    slot_t slot0;
    slot_t slot1;
  } pair_t;

  typedef struct packed {
    logic en;
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] data;
  } wb_t;

  // Port order is slot0 rs1, slot0 rs2, slot1 rs1, slot1 rs2.
  typedef struct packed {
    logic [read_ports-1:0] en;
    logic [read_ports-1:0][addr_width-1:0] addr;
  } read_req_t;

  typedef struct packed {
    logic [read_ports-1:0][data_width-1:0] data;
  } read_data_t;

  localparam slot_t empty_slot = '0;
  localparam pair_t empty_pair = '0;

endpackage

// ==== src/issue_stage.sv ====
`timescale 1ns/1ps

module issue_stage import issue_pkg::*; (
  input logic clock,
  input logic reset,
  input pair_t candidate,
  input logic split_busy,
  input logic pair_valid,
  input pair_t exec_pair,
  input pair_t mem_pair,
  input logic flush,
  output logic hold,
  output logic stall,
  output read_req_t read_req,
  output pair_t issued,
  output logic issued_valid
);

  logic load_use;
  logic csr_busy;
  logic hazard;
  logic candidate_valid;
  logic issue_now;

  function automatic logic reads_reg(input slot_t s, input logic [addr_width-1:0] r);
    return s.valid && ((s.rs1_en && (s.rs1 == r)) || (s.rs2_en && (s.rs2 == r)));
  endfunction

  // True when a load in execute produces a source that slot c needs now.
  function automatic logic load_feeds(input slot_t e, input slot_t c);
    logic is_load;
    is_load = e.valid && (e.kind == op_load) && e.rd_en && (e.rd != '0);
    return is_load && reads_reg(c, e.rd);
  endfunction

  function automatic logic csr_write(input slot_t s);
    return s.valid && (s.kind == op_csr_write);
  endfunction

  always_comb begin
    load_use = load_feeds(exec_pair.slot0, candidate.slot0) |
               load_feeds(exec_pair.slot1, candidate.slot0) |
               load_feeds(exec_pair.slot0, candidate.slot1) |
               load_feeds(exec_pair.slot1, candidate.slot1);

    // CSR writes serialize until they have left the memory stage.
    csr_busy = csr_write(exec_pair.slot0) | csr_write(exec_pair.slot1) |
               csr_write(mem_pair.slot0) | csr_write(mem_pair.slot1);

    hazard = load_use | csr_busy;
    hold = hazard;
    stall = !flush && (hazard || split_busy);

    candidate_valid = pair_valid && (candidate.slot0.valid || candidate.slot1.valid);
    issue_now = candidate_valid && !hazard && !flush;
  end

  always_comb begin
    read_req.en[0] = candidate.slot0.valid & candidate.slot0.rs1_en;
    read_req.en[1] = candidate.slot0.valid & candidate.slot0.rs2_en;
    read_req.en[2] = candidate.slot1.valid & candidate.slot1.rs1_en;
    read_req.en[3] = candidate.slot1.valid & candidate.slot1.rs2_en;
    read_req.addr[0] = candidate.slot0.rs1;
    read_req.addr[1] = candidate.slot0.rs2;
    read_req.addr[2] = candidate.slot1.rs1;
    read_req.addr[3] = candidate.slot1.rs2;
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      issued_valid <= 1'b0;
    end else begin
      issued_valid <= issue_now;
    end
  end

  always_ff @(posedge clock) begin
    if (issue_now) begin
      issued <= candidate;
    end else begin
      issued <= empty_pair; // Bubble.
    end
  end

endmodule

// ==== src/issue_top.sv ====
`timescale 1ns/1ps

module issue_top import issue_pkg::*; (
  input logic clock,
  input logic reset,
  input pair_t pair_in,
  input logic pair_valid,
  input logic flush,
  input wb_t wb0,
  input wb_t wb1,
  output pair_t issued,
  output logic issued_valid,
  output read_data_t operands,
  output logic stall
);

  pair_t candidate;
  pair_t exec_pair;
  pair_t mem_pair;
  logic split_busy;
  logic hold;
  read_req_t read_req;

  pair_splitter pair_splitter_inst (
    .clock(clock),
    .reset(reset),
    .pair_in(pair_in),
    .pair_valid(pair_valid),
    .hold(hold),
    .flush(flush),
    .candidate(candidate),
    .split_busy(split_busy)
  );

  issue_stage issue_stage_inst (
    .clock(clock),
    .reset(reset),
    .candidate(candidate),
    .split_busy(split_busy),
    .pair_valid(pair_valid),
    .exec_pair(exec_pair),
    .mem_pair(mem_pair),
    .flush(flush),
    .hold(hold),
    .stall(stall),
    .read_req(read_req),
    .issued(issued),
    .issued_valid(issued_valid)
  );

  pipe_shadow pipe_shadow_inst (
    .clock(clock),
    .reset(reset),
    .issued(issued),
    .issued_valid(issued_valid),
    .flush(flush),
    .exec_pair(exec_pair),
    .mem_pair(mem_pair)
  );

  // Operands are registered on the same edge as issued.
  register_file register_file_inst (
    .clock(clock),
    .reset(reset),
    .read_req(read_req),
    .wb0(wb0),
    .wb1(wb1),
    .operands(operands)
  );

endmodule

// ==== src/pair_splitter.sv ====
`timescale 1ns/1ps

module pair_splitter import issue_pkg::*; (
  input logic clock,
  input logic reset,
  input pair_t pair_in,
  input logic pair_valid,
  input logic hold,
  input logic flush,
  output pair_t candidate,
  output logic split_busy
);

  typedef enum logic {
    whole,
    second_half
  } split_state_t;

  split_state_t state;
  slot_t held_slot;
  logic must_split;

  // A pair cannot go out together if slot1 depends on slot0,
  // or if both want the single memory port.
  function automatic logic pair_conflict(input pair_t p);
    logic both_valid;
    logic raw;
    logic mem0;
    logic mem1;
    both_valid = p.slot0.valid & p.slot1.valid;
    raw = p.slot0.rd_en && (p.slot0.rd != '0) &&
          ((p.slot1.rs1_en && (p.slot1.rs1 == p.slot0.rd)) ||
           (p.slot1.rs2_en && (p.slot1.rs2 == p.slot0.rd)));
    mem0 = (p.slot0.kind == op_load) || (p.slot0.kind == op_store);
    mem1 = (p.slot1.kind == op_load) || (p.slot1.kind == op_store);
    return both_valid & (raw | (mem0 & mem1));
  endfunction

  always_comb begin
    must_split = pair_conflict(pair_in);
    split_busy = (state == whole) && pair_valid && must_split;
    candidate = empty_pair;
    if (state == second_half) begin
      candidate.slot0 = held_slot; // Younger op moves into slot0's position.
    end else if (pair_valid) begin
      candidate = pair_in;
      if (must_split) begin
        candidate.slot1 = empty_slot;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= whole;
    end else if (flush) begin
      state <= whole; // A pending half is dropped.
    end else if (!hold) begin
      case (state)
        whole: begin
          if (split_busy) begin
            state <= second_half;
          end
        end
        default: begin
          state <= whole;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (state == whole) begin
      held_slot <= pair_in.slot1;
    end
  end

endmodule

// ==== src/pipe_shadow.sv ====
`timescale 1ns/1ps

module pipe_shadow import issue_pkg::*; (
  input logic clock,
  input logic reset,
  input pair_t issued,
  input logic issued_valid,
  input logic flush,
  output pair_t exec_pair,
  output pair_t mem_pair
);

  // Stands in for the real execute and memory stages so that
  // hazard checks see what is still in flight.
  always_ff @(posedge clock) begin
    if (!reset) begin
      exec_pair <= empty_pair;
      mem_pair <= empty_pair;
    end else if (flush) begin
      exec_pair <= empty_pair;
      mem_pair <= empty_pair;
    end else begin
      if (issued_valid) begin
        exec_pair <= issued;
      end else begin
        exec_pair <= empty_pair;
      end
      mem_pair <= exec_pair;
    end
  end

endmodule

// ==== src/register_file.sv ====
`timescale 1ns/1ps

module register_file import issue_pkg::*; (
  input logic clock,
  input logic reset,
  input read_req_t read_req,
  input wb_t wb0,
  input wb_t wb1,
  output read_data_t operands
);

  logic [data_width-1:0] regs [reg_count];

  // The newest value wins. Port 1 beats port 0, and both beat the array.
  function automatic logic [data_width-1:0] read_port(
    input logic en,
    input logic [addr_width-1:0] addr
  );
    logic [data_width-1:0] value;
    if (!en || addr == '0) begin
      value = '0;
    end else if (wb1.en && wb1.addr == addr) begin
      value = wb1.data;
    end else if (wb0.en && wb0.addr == addr) begin
      value = wb0.data;
    end else begin
      value = regs[addr];
    end
    return value;
  endfunction

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
      operands <= '0;
    end else begin
      if (wb0.en && wb0.addr != '0) begin
        regs[wb0.addr] <= wb0.data;
      end
      if (wb1.en && wb1.addr != '0) begin
        regs[wb1.addr] <= wb1.data; // Port 1 is written last and wins a tie.
      end
      for (int p = 0; p < read_ports; p++) begin
        operands.data[p] <= read_port(read_req.en[p], read_req.addr[p]);
      end
    end
  end

endmodule

// ==== verification/issue_tb.sv ====
`timescale 1ns/1ps

module issue_tb import issue_pkg::*; ();

  localparam int period_ns = 100;
  localparam int reset_cycles = 5;
  localparam int num_cycles = 2000;
  localparam int accept_timeout = 20;

  logic clock;
  logic reset;
  pair_t pair_in;
  logic pair_valid;
  logic flush;
  wb_t wb0;
  wb_t wb1;
  pair_t issued;
  logic issued_valid;
  read_data_t operands;
  logic stall;

  logic [31:0] lfsr_state;
  logic [31:0] pc;

  // Reference model of the issue stage and the later stages it watches.
  logic [data_width-1:0] model_regs [reg_count];
  logic model_second;
  slot_t model_held;
  pair_t model_issued;
  logic model_issued_valid;
  pair_t model_exec;
  pair_t model_mem;
  read_data_t model_operands;
  logic model_stall;

  int cycle_count;
  int whole_count;
  int split_count;
  int load_use_count;
  int csr_count;
  int flush_drop_count;
  int bypass_count;
  int tie_count;
  int zero_read_count;

  tb_clock #(.period_ns(period_ns)) tb_clock_inst (.clock(clock));

  issue_top issue_top_inst (
    .clock(clock),
    .reset(reset),
    .pair_in(pair_in),
    .pair_valid(pair_valid),
    .flush(flush),
    .wb0(wb0),
    .wb1(wb1),
    .issued(issued),
    .issued_valid(issued_valid),
    .operands(operands),
    .stall(stall)
  );

  function automatic logic [31:0] galois_step(input logic [31:0] s);
    logic [31:0] next;
    next = s >> 1;
    if (s[0]) begin
      next = next ^ 32'h80200003;
    end
    return next;
  endfunction

  // One LFSR step per bit handed out.
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      value = {value[30:0], lfsr_state[0]};
      lfsr_state = galois_step(lfsr_state);
    end
    return value;
  endfunction

  // Registers come mostly from x0 to x7 so that dependencies and bypasses are common.
  function automatic logic [addr_width-1:0] random_reg();
    logic [addr_width-1:0] r;
    if (random_bits(2) != 0) begin
      r = addr_width'(random_bits(3));
    end else begin
      r = addr_width'(random_bits(5));
    end
    return r;
  endfunction

  function automatic slot_t random_slot(input logic [31:0] slot_pc);
    slot_t s;
    logic [2:0] k;
    k = 3'(random_bits(3));
    if (k > 3'd5) begin
      k = 3'd1;
    end
    s.valid = 1'b1;
    s.kind = op_kind_t'(k);
    s.pc = slot_pc;
    s.rd = random_reg();
    s.rs1 = random_reg();
    s.rs2 = random_reg();
    s.rd_en = (random_bits(2) != 0);
    s.rs1_en = 1'(random_bits(1));
    s.rs2_en = 1'(random_bits(1));
    return s;
  endfunction

  function automatic pair_t random_pair(input logic [31:0] pair_pc);
    pair_t p;
    p.slot0 = random_slot(pair_pc);
    if (random_bits(3) != 0) begin
      p.slot1 = random_slot(pair_pc + 32'd4);
    end else begin
      p.slot1 = empty_slot;
    end
    return p;
  endfunction

  function automatic wb_t random_wb();
    wb_t w;
    w.en = 1'(random_bits(1));
    w.addr = random_reg();
    w.data = random_bits(32);
    return w;
  endfunction

  function automatic logic reads_source(input slot_t s, input logic [addr_width-1:0] r);
    return s.valid && ((s.rs1_en && s.rs1 == r) || (s.rs2_en && s.rs2 == r));
  endfunction

  function automatic logic is_mem_op(input slot_t s);
    return s.kind == op_load || s.kind == op_store;
  endfunction

  // Split when slot1 needs slot0's result or both need the memory port.
  function automatic logic must_split(input pair_t p);
    logic dep;
    dep = p.slot0.rd_en && p.slot0.rd != 0 && reads_source(p.slot1, p.slot0.rd);
    return p.slot0.valid && p.slot1.valid && (dep || (is_mem_op(p.slot0) && is_mem_op(p.slot1)));
  endfunction

  function automatic logic load_blocks(input slot_t e, input pair_t c);
    if (!(e.valid && e.kind == op_load && e.rd_en && e.rd != 0)) begin
      return 1'b0;
    end
    return reads_source(c.slot0, e.rd) || reads_source(c.slot1, e.rd);
  endfunction

  function automatic logic is_csr_write(input slot_t s);
    return s.valid && s.kind == op_csr_write;
  endfunction

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped after the first error.");
  endtask

  task automatic check_value(input string what, input logic [127:0] actual,
                             input logic [127:0] expected);
    if (actual !== expected) begin
      stop_run($sformatf("[FAIL] t=%0t %s mismatch: got %h, expected %h",
                         $time, what, actual, expected));
    end
  endtask

  task automatic check_outputs();
    check_value("issued_valid", 128'(issued_valid), 128'(model_issued_valid));
    check_value("issued", 128'(issued), 128'(model_issued));
    check_value("operands", 128'(operands), 128'(model_operands));
  endtask

  // Reports a behavior that the run never exercised.
  function automatic logic covered(input string what, input int count);
    if (count == 0) begin
      $display("Coverage hole: no %s was seen during the run.", what);
    end
    return count != 0;
  endfunction

  // Writes land first, so a read of the same register sees the new value.
  task automatic update_registers(input pair_t cand);
    logic [3:0][addr_width-1:0] addr;
    logic [3:0] en;
    addr = {cand.slot1.rs2, cand.slot1.rs1, cand.slot0.rs2, cand.slot0.rs1};
    en = {cand.slot1.valid & cand.slot1.rs2_en, cand.slot1.valid & cand.slot1.rs1_en,
          cand.slot0.valid & cand.slot0.rs2_en, cand.slot0.valid & cand.slot0.rs1_en};
    if (wb0.en && wb1.en && wb0.addr == wb1.addr && wb0.addr != 0) begin
      tie_count++;
    end
    if (wb0.en && wb0.addr != 0) begin
      model_regs[wb0.addr] = wb0.data;
    end
    if (wb1.en && wb1.addr != 0) begin
      model_regs[wb1.addr] = wb1.data;
    end
    for (int p = 0; p < 4; p++) begin
      if (!en[p] || addr[p] == 0) begin
        model_operands.data[p] = '0;
        zero_read_count += int'(en[p]);
      end else begin
        model_operands.data[p] = model_regs[addr[p]];
        if ((wb0.en && wb0.addr == addr[p]) || (wb1.en && wb1.addr == addr[p])) begin
          bypass_count++;
        end
      end
    end
  endtask

  // Starts at a falling edge and ends at the next one.
  task automatic run_cycle(input pair_t p, input logic valid, output logic accepted);
    pair_t cand;
    logic split_now;
    logic load_use;
    logic csr_busy;
    logic hazard;
    logic issue;
    pair_in = p;
    pair_valid = valid;
    flush = (random_bits(5) == 0);
    wb0 = random_wb();
    wb1 = random_wb();
    if (random_bits(3) == 0) begin
      wb1.addr = wb0.addr;
    end
    cand = empty_pair;
    split_now = !model_second && valid && must_split(p);
    if (model_second) begin
      cand.slot0 = model_held; // Younger op in slot0's position.
    end else if (valid) begin
      cand = p;
      if (split_now) begin
        cand.slot1 = empty_slot;
      end
    end
    load_use = load_blocks(model_exec.slot0, cand) || load_blocks(model_exec.slot1, cand);
    csr_busy = is_csr_write(model_exec.slot0) || is_csr_write(model_exec.slot1) ||
               is_csr_write(model_mem.slot0) || is_csr_write(model_mem.slot1);
    hazard = load_use || csr_busy;
    model_stall = !flush && (hazard || split_now);
    issue = valid && (cand.slot0.valid || cand.slot1.valid) && !hazard && !flush;
    accepted = valid && !model_stall;
    #(period_ns / 4);
    check_value("stall", 128'(stall), 128'(model_stall));
    load_use_count += int'(load_use && !flush);
    csr_count += int'(csr_busy && !flush);
    flush_drop_count += int'(flush && model_second);
    split_count += int'(issue && model_second);
    whole_count += int'(issue && cand.slot0.valid && cand.slot1.valid);
    update_registers(cand);
    model_mem = flush ? empty_pair : model_exec;
    model_exec = (flush || !model_issued_valid) ? empty_pair : model_issued;
    model_issued = issue ? cand : empty_pair;
    model_issued_valid = issue;
    if (!model_second) begin
      model_held = p.slot1;
    end
    if (flush) begin
      model_second = 1'b0;
    end else if (!hazard) begin
      model_second = split_now;
    end
    cycle_count++;
    @(negedge clock);
    check_outputs();
  endtask

  // Holds the pair until the issue stage takes it.
  task automatic offer_pair(input pair_t p);
    int waited;
    logic accepted;
    waited = 0;
    accepted = 1'b0;
    while (!accepted) begin
      if (waited == accept_timeout) begin
        stop_run("Timeout: stall stayed high and a pair was never accepted.");
      end
      run_cycle(p, 1'b1, accepted);
      waited++;
    end
  endtask

  initial begin
    logic accepted;
    logic all_seen;
    lfsr_state = 32'hce9fc96c;
    pc = 32'h0000_1000;
    reset = 1'b0;
    pair_in = empty_pair;
    pair_valid = 1'b0;
    flush = 1'b0;
    wb0 = '0;
    wb1 = '0;
    for (int i = 0; i < reg_count; i++) begin
      model_regs[i] = '0;
    end
    model_second = 1'b0;
    model_held = empty_slot;
    model_issued = empty_pair;
    model_issued_valid = 1'b0;
    model_exec = empty_pair;
    model_mem = empty_pair;
    model_operands = '0;
    model_stall = 1'b0;
    for (int i = 0; i < reset_cycles; i++) begin
      @(posedge clock);
    end
    @(negedge clock);
    reset = 1'b1;
    check_outputs();
    check_value("stall after reset", 128'(stall), 128'(1'b0));

    while (cycle_count < num_cycles) begin
      if (random_bits(3) == 0) begin
        run_cycle(empty_pair, 1'b0, accepted);
      end else begin
        offer_pair(random_pair(pc));
        pc = pc + 32'd8;
      end
    end

    $display("Cycles %0d, whole %0d, split %0d, load-use %0d, csr %0d, dropped halves %0d",
             cycle_count, whole_count, split_count, load_use_count, csr_count,
             flush_drop_count);
    all_seen = covered("whole pair issue", whole_count);
    all_seen &= covered("split pair", split_count);
    all_seen &= covered("load-use stall", load_use_count);
    all_seen &= covered("CSR stall", csr_count);
    all_seen &= covered("flush of a pending half", flush_drop_count);
    all_seen &= covered("writeback bypass", bypass_count);
    all_seen &= covered("same-address writeback pair", tie_count);
    all_seen &= covered("read of x0", zero_read_count);
    if (all_seen) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      stop_run("Some behaviors were never exercised during the run.");
    end
  end

endmodule

// ==== verification/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
  parameter int period_ns = 100
) (
  output logic clock
);

  // The clock runs freely and first rises half a period after time zero.
  initial begin
    clock = 1'b0;
    forever begin
      #(period_ns / 2) clock = ~clock;
    end
  end

endmodule
